/* src.f */
+incdir+common
common/mips_pkg.sv
cpu/mips_alu.sv
cpu/mips_reg_file.sv
cpu/mips_control.sv
cpu/mips_cpu_bus.sv
test/mips_bus_mem.sv
test/mips_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = mips_tb
FILELIST  = src.f
BUILD_DIR = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* test/mips_tb.sv */
// Testbench for the multicycle MIPS core with an Avalon bus port.
// Directed programs for arithmetic, load and store, jumps, wait states and halt,
// with compare tasks, a cycle watchdog and a closing summary.

`timescale 1ns/1ps

`include "mips_defines.svh"

module mips_tb;

    localparam logic [31:0] DATA_BASE       = 32'h0000_1000;
    localparam int          NUM_TESTS       = 5;
    localparam int          CYCLES_PER_TEST = 400;
    localparam int          TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;

    logic        clk;
    logic        reset;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;

    // memory model controls
    logic        stall_en;
    logic        clear_mem;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic [31:0] peek_addr;
    logic [31:0] peek_data;

    int          error_count;
    int          check_count;
    int          cycle_count;
    string       current_test;
    logic [31:0] prog_words[$];

    mips_cpu_bus u_dut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    mips_bus_mem u_mem (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .stall_en    (stall_en),
        .clear_mem   (clear_mem),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .peek_addr   (peek_addr),
        .peek_data   (peek_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // instruction encoders, straight from the MIPS field layout
    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input mips_pkg::funct_t fn);
        return {mips_pkg::OPCODE_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input mips_pkg::opcode_t op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input mips_pkg::opcode_t op, input logic [31:0] dest);
        return {op, dest[27:2]};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] prog_addr(input int idx);
        return `MIPS_RESET_VECTOR + 32'(idx * 4);
    endfunction

    task automatic check_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
                     current_test, what, expected, actual);
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s %s: expected %b, actual %b",
                     current_test, what, expected, actual);
        end
    endtask

    task automatic read_mem(input logic [31:0] addr, output logic [31:0] data);
        peek_addr = addr;
        @(posedge clk);
        data = peek_data;
    endtask

    // loads the program under reset, releases the core and waits for it to halt
    task automatic run_program(input logic stall);
        @(negedge clk);
        reset     = 1'b1;
        stall_en  = stall;
        clear_mem = 1'b1;
        @(negedge clk);
        clear_mem = 1'b0;
        foreach (prog_words[i]) begin
            load_en   = 1'b1;
            load_addr = prog_addr(i);
            load_data = prog_words[i];
            @(negedge clk);
        end
        load_en = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_bit("active after reset", 1'b1, active);
        while (active) begin
            @(negedge clk);
        end
    endtask

    task automatic test_arithmetic();
        logic [31:0] expected;
        current_test = "arithmetic";
        expected = sext16(16'h7FFF) + sext16(16'hFFF9) + sext16(16'h8000);
        prog_words.delete();
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd0, 5'd8, 16'h7FFF));
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd0, 5'd9, 16'hFFF9));
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd9, 5'd9, 16'h8000));
        prog_words.push_back(enc_r(5'd8, 5'd9, 5'd2, mips_pkg::FUNCT_ADDU));
        prog_words.push_back(enc_r(5'd0, 5'd0, 5'd0, mips_pkg::FUNCT_JR));
        run_program(1'b0);
        check_word("register_v0", expected, register_v0);
    endtask

    task automatic test_store_load(input logic stall, input string name);
        logic [31:0] value;
        logic [31:0] base;
        logic [31:0] word;
        current_test = name;
        base  = DATA_BASE + 32'h10;
        value = 32'h1234 + 32'h1234 + sext16(16'hABCD);
        prog_words.delete();
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd0, 5'd8, base[15:0]));
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd0, 5'd9, 16'h1234));
        prog_words.push_back(enc_r(5'd9, 5'd9, 5'd9, mips_pkg::FUNCT_ADDU));
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd9, 5'd9, 16'hABCD));
        prog_words.push_back(enc_i(mips_pkg::OPCODE_SW, 5'd8, 5'd9, 16'hFFF8));
        prog_words.push_back(enc_i(mips_pkg::OPCODE_LW, 5'd8, 5'd2, 16'hFFF8));
        prog_words.push_back(enc_r(5'd0, 5'd0, 5'd0, mips_pkg::FUNCT_JR));
        run_program(stall);
        check_word("register_v0", value, register_v0);
        read_mem(base + sext16(16'hFFF8), word);
        check_word("stored word", value, word);
    endtask

    // word 2 must be jumped over and the routine at word 6 must run once
    task automatic test_jumps(input logic stall, input string name);
        logic [31:0] expected;
        logic [31:0] link;
        logic [31:0] stored;
        current_test = name;
        expected = 32'd5 + sext16(16'h0020);
        link     = prog_addr(3) + 32'd4;
        prog_words.delete();
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd0, 5'd2, 16'h0005));
        prog_words.push_back(enc_j(mips_pkg::OPCODE_J, prog_addr(3)));
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd2, 5'd2, 16'h0100));
        prog_words.push_back(enc_j(mips_pkg::OPCODE_JAL, prog_addr(6)));
        prog_words.push_back(enc_r(5'd0, 5'd0, 5'd0, mips_pkg::FUNCT_JR));
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd2, 5'd2, 16'h0100));
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd2, 5'd2, 16'h0020));
        prog_words.push_back(enc_i(mips_pkg::OPCODE_SW, 5'd0, 5'd31, DATA_BASE[15:0]));
        prog_words.push_back(enc_r(5'd31, 5'd0, 5'd0, mips_pkg::FUNCT_JR));
        run_program(stall);
        check_word("register_v0", expected, register_v0);
        read_mem(DATA_BASE, stored);
        check_word("link register", link, stored);
    endtask

    task automatic test_halt_zero();
        logic bus_seen;
        current_test = "halt and register zero";
        bus_seen = 1'b0;
        prog_words.delete();
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd0, 5'd2, 16'h0077));
        prog_words.push_back(enc_i(mips_pkg::OPCODE_ADDIU, 5'd0, 5'd0, 16'h0055));
        prog_words.push_back(enc_r(5'd0, 5'd0, 5'd2, mips_pkg::FUNCT_ADDU));
        prog_words.push_back(enc_r(5'd0, 5'd0, 5'd0, mips_pkg::FUNCT_JR));
        run_program(1'b0);
        check_word("register_v0", 32'd0, register_v0);
        repeat (20) begin
            @(negedge clk);
            bus_seen = bus_seen | read | write;
        end
        check_bit("active", 1'b0, active);
        check_bit("bus request after halt", 1'b0, bus_seen);
    endtask

    initial begin : watchdog
        mips_pkg::state_t stuck_state;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        stuck_state = u_dut.u_control.state;
        $display("timeout: the core did not halt within %0d cycles, stuck in state %s",
                 TIMEOUT_CYCLES, stuck_state.name());
        error_count++;
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        stall_en    = 1'b0;
        clear_mem   = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        peek_addr   = '0;
        error_count = 0;
        check_count = 0;
        test_arithmetic();
        test_store_load(1'b0, "store load");
        test_jumps(1'b0, "jumps");
        test_store_load(1'b1, "store load with stalls");
        test_jumps(1'b1, "jumps with stalls");
        test_halt_zero();
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* test/mips_bus_mem.sv */
// Testbench memory model for the MIPS core.
// Program window at the reset vector, data window at a low address,
// optional random wait states, and load and peek ports for the testbench.

`timescale 1ns/1ps

`include "mips_defines.svh"

module mips_bus_mem (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    output logic [31:0] readdata,
    output logic        waitrequest,
    input  logic        stall_en,
    input  logic        clear_mem,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    input  logic [31:0] peek_addr,
    output logic [31:0] peek_data
);

    localparam logic [31:0] PROG_BASE = `MIPS_RESET_VECTOR;
    localparam logic [31:0] DATA_BASE = 32'h0000_1000;
    localparam int          WORDS     = 128;

    logic [31:0] words [WORDS];
    logic [1:0]  wait_cnt;
    logic [7:0]  bus_slot;
    logic [7:0]  load_slot;
    logic [7:0]  peek_slot;

    // slots 0 to 63 hold the program window, 64 to 127 the data window
    // bit 7 of the result is set when the address hits neither window
    function automatic logic [7:0] locate(input logic [31:0] addr);
        if (addr[31:8] == PROG_BASE[31:8]) begin
            return {2'b00, addr[7:2]};
        end else if (addr[31:8] == DATA_BASE[31:8]) begin
            return {2'b01, addr[7:2]};
        end
        return 8'h80;
    endfunction

    function automatic logic [31:0] word_address(input int slot);
        if (slot < 64) begin
            return PROG_BASE + 32'(slot * 4);
        end
        return DATA_BASE + 32'((slot - 64) * 4);
    endfunction

    // unwritten words read back as a value tied to their own address
    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return addr ^ 32'hC3C3_C3C3;
    endfunction

    assign bus_slot  = locate(address);
    assign load_slot = locate(load_addr);
    assign peek_slot = locate(peek_addr);

    assign readdata    = bus_slot[7] ? fill_pattern(address) : words[bus_slot[6:0]];
    assign peek_data   = peek_slot[7] ? fill_pattern(peek_addr) : words[peek_slot[6:0]];
    assign waitrequest = (read || write) && (wait_cnt != 2'd0);

    initial begin
        void'($urandom(32'h644fc20c));
    end

    always @(posedge clk) begin
        // a fresh stall length is drawn for the next request after each transfer
        if (reset || ((read || write) && !waitrequest)) begin
            wait_cnt <= stall_en ? 2'($urandom_range(3, 0)) : 2'd0;
        end else if (waitrequest) begin
            wait_cnt <= wait_cnt - 2'd1;
        end

        if (clear_mem) begin
            for (int i = 0; i < WORDS; i++) begin
                words[i] <= fill_pattern(word_address(i));
            end
        end else if (load_en && !load_slot[7]) begin
            words[load_slot[6:0]] <= load_data;
        end else if (write && !waitrequest && !bus_slot[7]) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    words[bus_slot[6:0]][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* cpu/mips_cpu_bus.sv */
// Top level of the multicycle MIPS core with an Avalon bus master port.
// Connects the control unit, the register file and the ALU.

`timescale 1ns/1ps

`include "mips_defines.svh"

module mips_cpu_bus (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   active,
    output logic [`MIPS_XLEN-1:0]  register_v0,
    output logic [`MIPS_XLEN-1:0]  address,
    output logic                   write,
    output logic                   read,
    input  logic                   waitrequest,
    output logic [`MIPS_XLEN-1:0]  writedata,
    output logic [3:0]             byteenable,
    input  logic [`MIPS_XLEN-1:0]  readdata
);

    // register file ports
    logic [4:0]            rs_addr;
    logic [4:0]            rt_addr;
    logic [`MIPS_XLEN-1:0] rs_val;
    logic [`MIPS_XLEN-1:0] rt_val;
    logic                  reg_write;
    logic [4:0]            reg_write_addr;
    logic [`MIPS_XLEN-1:0] reg_write_data;

    // ALU ports
    mips_pkg::opcode_t     opcode;
    mips_pkg::funct_t      funct;
    logic [`MIPS_XLEN-1:0] alu_b;
    logic [`MIPS_XLEN-1:0] alu_result;

    mips_control u_control (
        .clk            (clk),
        .reset          (reset),
        .waitrequest    (waitrequest),
        .readdata       (readdata),
        .rs_val         (rs_val),
        .rt_val         (rt_val),
        .alu_result     (alu_result),
        .active         (active),
        .address        (address),
        .read           (read),
        .write          (write),
        .writedata      (writedata),
        .byteenable     (byteenable),
        .rs_addr        (rs_addr),
        .rt_addr        (rt_addr),
        .reg_write      (reg_write),
        .reg_write_addr (reg_write_addr),
        .reg_write_data (reg_write_data),
        .opcode         (opcode),
        .funct          (funct),
        .alu_b          (alu_b)
    );

    mips_reg_file u_reg_file (
        .clk         (clk),
        .reset       (reset),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .write       (reg_write),
        .write_addr  (reg_write_addr),
        .write_data  (reg_write_data),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .register_v0 (register_v0)
    );

    // operand A always comes straight from rs
    mips_alu u_alu (
        .a      (rs_val),
        .b      (alu_b),
        .opcode (opcode),
        .funct  (funct),
        .result (alu_result)
    );

endmodule

/* cpu/mips_control.sv */
// Control unit of the multicycle MIPS core.
// Holds the PC, instruction register and FSM, decodes the instruction
// and acts as the Avalon bus master for fetch, load and store.

`timescale 1ns/1ps

`include "mips_defines.svh"

module mips_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   waitrequest,
    input  logic [`MIPS_XLEN-1:0]  readdata,
    input  logic [`MIPS_XLEN-1:0]  rs_val,
    input  logic [`MIPS_XLEN-1:0]  rt_val,
    input  logic [`MIPS_XLEN-1:0]  alu_result,
    output logic                   active,
    output logic [`MIPS_XLEN-1:0]  address,
    output logic                   read,
    output logic                   write,
    output logic [`MIPS_XLEN-1:0]  writedata,
    output logic [3:0]             byteenable,
    output logic [4:0]             rs_addr,
    output logic [4:0]             rt_addr,
    output logic                   reg_write,
    output logic [4:0]             reg_write_addr,
    output logic [`MIPS_XLEN-1:0]  reg_write_data,
    output mips_pkg::opcode_t      opcode,
    output mips_pkg::funct_t       funct,
    output logic [`MIPS_XLEN-1:0]  alu_b
);

    mips_pkg::state_t      state;
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] ir;
    logic [`MIPS_XLEN-1:0] load_data;

    // decoded fields of the held instruction
    mips_pkg::format_t     format;
    logic [4:0]            rd_field;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [25:0]           target;
    logic [4:0]            dest_addr;

    // jump resolution
    logic                  is_jump;
    logic [`MIPS_XLEN-1:0] jump_target;

    // bus requests before the reset gate
    logic                  bus_read;
    logic                  bus_write;

    assign opcode   = mips_pkg::opcode_t'(ir[31:26]);
    assign funct    = mips_pkg::funct_t'(ir[5:0]);
    assign rs_addr  = ir[25:21];
    assign rt_addr  = ir[20:16];
    assign rd_field = ir[15:11];
    assign target   = ir[25:0];
    assign imm_ext  = {{(`MIPS_XLEN-16){ir[15]}}, ir[15:0]};

    always_comb begin
        case (opcode)
            mips_pkg::OPCODE_RTYPE: format = mips_pkg::FORMAT_R;
            mips_pkg::OPCODE_J,
            mips_pkg::OPCODE_JAL:   format = mips_pkg::FORMAT_J;
            default:                format = mips_pkg::FORMAT_I;
        endcase
    end

    // R-type writes rd, I-type writes rt and JAL links into the last register
    always_comb begin
        case (format)
            mips_pkg::FORMAT_R: dest_addr = rd_field;
            mips_pkg::FORMAT_J: dest_addr = 5'(`MIPS_NUM_REGS - 1);
            default:            dest_addr = rt_addr;
        endcase
    end

    assign alu_b = (format == mips_pkg::FORMAT_R) ? rt_val : imm_ext;

    // pc already points past the jump, so its top bits are the region of the target
    assign is_jump = (format == mips_pkg::FORMAT_J) ||
                     (format == mips_pkg::FORMAT_R && funct == mips_pkg::FUNCT_JR);
    assign jump_target = (format == mips_pkg::FORMAT_J) ? {pc[31:28], target, 2'b00}
                                                        : rs_val;

    // bus and register file write controls for each state
    always_comb begin
        bus_read       = 1'b0;
        bus_write      = 1'b0;
        address        = pc;
        reg_write      = 1'b0;
        reg_write_addr = dest_addr;
        reg_write_data = alu_result;
        case (state)
            mips_pkg::STATE_FETCH: begin
                bus_read = 1'b1;
            end
            mips_pkg::STATE_EXECUTE: begin
                case (opcode)
                    mips_pkg::OPCODE_RTYPE: begin
                        reg_write = (funct == mips_pkg::FUNCT_ADDU);
                    end
                    mips_pkg::OPCODE_ADDIU: begin
                        reg_write = 1'b1;
                    end
                    mips_pkg::OPCODE_JAL: begin
                        // pc already holds the JAL address plus 4
                        reg_write      = 1'b1;
                        reg_write_data = pc;
                    end
                    mips_pkg::OPCODE_LW: begin
                        bus_read = 1'b1;
                        address  = alu_result;
                    end
                    mips_pkg::OPCODE_SW: begin
                        bus_write = 1'b1;
                        address   = alu_result;
                    end
                    default: begin
                    end
                endcase
            end
            mips_pkg::STATE_MEMORY: begin
                reg_write      = 1'b1;
                reg_write_data = load_data;
            end
            default: begin
            end
        endcase
    end

    // no bus traffic may leave the core while reset is held
    assign read       = bus_read && !reset;
    assign write      = bus_write && !reset;
    assign writedata  = rt_val;
    assign byteenable = 4'b1111;
    assign active     = (state != mips_pkg::STATE_HALT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_pkg::STATE_FETCH;
            pc    <= `MIPS_RESET_VECTOR;
        end else begin
            case (state)
                mips_pkg::STATE_FETCH: begin
                    if (!waitrequest) begin
                        pc    <= pc + 32'd4;
                        state <= mips_pkg::STATE_EXECUTE;
                    end
                end
                mips_pkg::STATE_EXECUTE: begin
                    case (opcode)
                        mips_pkg::OPCODE_LW: begin
                            if (!waitrequest) begin
                                state <= mips_pkg::STATE_MEMORY;
                            end
                        end
                        mips_pkg::OPCODE_SW: begin
                            if (!waitrequest) begin
                                state <= mips_pkg::STATE_FETCH;
                            end
                        end
                        default: begin
                            if (is_jump) begin
                                pc <= jump_target;
                            end
                            // a jump to address zero ends the program
                            if (is_jump && jump_target == '0) begin
                                state <= mips_pkg::STATE_HALT;
                            end else begin
                                state <= mips_pkg::STATE_FETCH;
                            end
                        end
                    endcase
                end
                mips_pkg::STATE_MEMORY: begin
                    state <= mips_pkg::STATE_FETCH;
                end
                default: begin
                    // stay halted until the next reset
                end
            endcase
        end
    end

    // the instruction and load data are captured on the completing bus cycle
    always_ff @(posedge clk) begin
        if (state == mips_pkg::STATE_FETCH && !waitrequest) begin
            ir <= readdata;
        end
        if (state == mips_pkg::STATE_EXECUTE && opcode == mips_pkg::OPCODE_LW &&
            !waitrequest) begin
            load_data <= readdata;
        end
    end

    a_no_read_and_write: assert property (
        @(posedge clk) disable iff (reset)
        !(read && write)
    );

    a_word_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (read || write) |-> (address[1:0] == 2'b00)
    );

    // a stalled request must be presented unchanged until it completes
    a_hold_on_wait: assert property (
        @(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=>
            ($stable(address) && $stable(read) && $stable(write) &&
             $stable(writedata) && $stable(byteenable))
    );

endmodule

/* cpu/mips_reg_file.sv */
// Register file of the MIPS core.
// Two combinational read ports, one write port, register 0 fixed at zero
// and register 2 exported as register_v0.

`timescale 1ns/1ps

`include "mips_defines.svh"

module mips_reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [4:0]             rs_addr,
    input  logic [4:0]             rt_addr,
    input  logic                   write,
    input  logic [4:0]             write_addr,
    input  logic [`MIPS_XLEN-1:0]  write_data,
    output logic [`MIPS_XLEN-1:0]  rs_val,
    output logic [`MIPS_XLEN-1:0]  rt_val,
    output logic [`MIPS_XLEN-1:0]  register_v0
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write && write_addr != 5'd0) begin
            regs[write_addr] <= write_data;
        end
    end

    // reads see the stored value, a write lands at the next edge
    assign rs_val = regs[rs_addr];
    assign rt_val = regs[rt_addr];

    // v0 carries the program result to the outside
    assign register_v0 = regs[2];

endmodule

/* cpu/mips_alu.sv */
// ALU of the MIPS core.
// Picks the operation from opcode and function code, then computes
// the result combinationally.

`timescale 1ns/1ps

`include "mips_defines.svh"

module mips_alu (
    input  logic [`MIPS_XLEN-1:0]  a,
    input  logic [`MIPS_XLEN-1:0]  b,
    input  mips_pkg::opcode_t      opcode,
    input  mips_pkg::funct_t       funct,
    output logic [`MIPS_XLEN-1:0]  result
);

    mips_pkg::alu_op_t alu_op;

    // loads and stores use the adder for base plus offset
    always_comb begin
        case (opcode)
            mips_pkg::OPCODE_RTYPE: begin
                if (funct == mips_pkg::FUNCT_ADDU) begin
                    alu_op = mips_pkg::ALU_ADD;
                end else begin
                    alu_op = mips_pkg::ALU_PASS_B;
                end
            end
            mips_pkg::OPCODE_ADDIU,
            mips_pkg::OPCODE_LW,
            mips_pkg::OPCODE_SW: alu_op = mips_pkg::ALU_ADD;
            default:             alu_op = mips_pkg::ALU_PASS_B;
        endcase
    end

    // the carry out is dropped, the unsigned forms never trap on overflow
    always_comb begin
        case (alu_op)
            mips_pkg::ALU_ADD: result = a + b;
            default:           result = b;
        endcase
    end

endmodule

/* common/mips_pkg.sv */
// Shared types for the multicycle MIPS core.
// Opcode and function-code encodings, FSM states, instruction formats
// and ALU operations.

package mips_pkg;

    // primary opcode field, bits 31:26 of the instruction
    typedef enum logic [5:0] {
        OPCODE_RTYPE = 6'b00_0000,
        OPCODE_J     = 6'b00_0010,
        OPCODE_JAL   = 6'b00_0011,
        OPCODE_ADDIU = 6'b00_1001,
        OPCODE_LW    = 6'b10_0011,
        OPCODE_SW    = 6'b10_1011
    } opcode_t;

    // function field of R-type instructions, bits 5:0
    typedef enum logic [5:0] {
        FUNCT_JR   = 6'b00_1000,
        FUNCT_ADDU = 6'b10_0001
    } funct_t;

    // control FSM states
    typedef enum logic [1:0] {
        STATE_FETCH   = 2'd0,
        STATE_EXECUTE = 2'd1,
        STATE_MEMORY  = 2'd2,
        STATE_HALT    = 2'd3
    } state_t;

    // instruction format, decides operand B and the destination register
    typedef enum logic [1:0] {
        FORMAT_R = 2'd0,
        FORMAT_I = 2'd1,
        FORMAT_J = 2'd2
    } format_t;

    // operations the ALU can perform
    typedef enum logic [1:0] {
        ALU_ADD    = 2'd0,
        ALU_PASS_B = 2'd1
    } alu_op_t;

endpackage

/* common/mips_defines.svh */
// Core-wide constants for the MIPS core.
// Reset vector, data path width and register count.

`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// first instruction is fetched from here after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// width of the data path, the registers and the bus
`define MIPS_XLEN 32

// number of general purpose registers
// the last one is the link register used by JAL
`define MIPS_NUM_REGS 32

`endif
